// File: fpu_add_sub.sv
`timescale 1ns/1ps
/* FPU add/sub datapath
   aligns exponents, then adds or subtracts two's complement mantissas */
module fpu_add_sub (
  input  logic [fpu_pkg::word_width-1:0]        operand_a,
  input  logic [fpu_pkg::word_width-1:0]        operand_b,
  input  fpu_pkg::fpu_op_e                      operation,
  output logic                                  sum_sign,
  output logic [fpu_pkg::frac_width+2:0]        sum_mag,
  output logic signed [fpu_pkg::exp_width-1:0]  sum_exp,
  output logic                                  sum_zero,
  output logic                                  a_zero
);

  localparam int fw = fpu_pkg::frac_width;
  localparam int ew = fpu_pkg::exp_width;

  logic [ew-1:0] a_exp;
  logic [ew-1:0] b_exp;
  logic signed [ew-1:0] a_unb;
  logic signed [ew-1:0] b_unb;
  logic [fw+2:0] a_mant;
  logic [fw+2:0] b_mant;
  logic [fw+2:0] a_al;
  logic [fw+2:0] b_al;
  logic [fw+2:0] raw;
  logic b_zero;

  assign a_exp  = operand_a[fw +: ew];
  assign b_exp  = operand_b[fw +: ew];
  assign a_unb  = a_exp - fpu_pkg::exp_bias;
  assign b_unb  = b_exp - fpu_pkg::exp_bias;
  // two guard bits on top for carry and sign
  assign a_mant = {2'b00, a_exp != '0, operand_a[fw-1:0]};
  assign b_mant = {2'b00, b_exp != '0, operand_b[fw-1:0]};
  assign a_zero = (a_exp == '0) && (operand_a[fw-1:0] == '0);
  assign b_zero = (b_exp == '0) && (operand_b[fw-1:0] == '0);

  always_comb begin
    a_al = a_mant;
    b_al = b_mant;
    // smaller one shifts right, dropped bits are lost
    if (a_exp < b_exp && !a_zero) a_al = a_mant >> (b_exp - a_exp);
    if (b_exp < a_exp && !b_zero) b_al = b_mant >> (a_exp - b_exp);
    if (operand_a[fpu_pkg::word_width-1]) a_al = -a_al;
    if (operand_b[fpu_pkg::word_width-1]) b_al = -b_al;
    if (operation == fpu_pkg::op_add) raw = a_al + b_al;
    else raw = a_al - b_al;
  end

  assign sum_zero = raw == '0;
  assign sum_sign = raw[fw+2];
  assign sum_mag  = sum_sign ? -raw : raw;
  assign sum_exp  = (a_zero || b_exp > a_exp) ? b_unb : a_unb;

endmodule

// File: fpu_assert.sv
`timescale 1ns/1ps
/* FPU controller assertions
   cmd_end/end_ack handshake and exclusive datapath strobes */
module fpu_assert (
  input logic clk,
  input logic arst,
  input logic cmd_end,
  input logic busy,
  input logic end_ack,
  input logic mul_start,
  input logic load_result
);

  end_implies_busy: assert property (@(posedge clk) disable iff (arst) cmd_end |-> busy)
    else $error("cmd_end is high while busy is low");

  // the host has to acknowledge before cmd_end may drop
  end_falls_on_ack: assert property (@(posedge clk) disable iff (arst)
    $fell(cmd_end) |-> $past(end_ack))
    else $error("cmd_end fell without end_ack in the previous cycle");

  strobes_exclusive: assert property (@(posedge clk) disable iff (arst)
    !(mul_start && load_result))
    else $error("mul_start and load_result are high together");

endmodule

bind fpu_control fpu_assert u_assert (
  .clk, .arst, .cmd_end, .busy, .end_ack, .mul_start, .load_result
);

// File: fpu_control.sv
`timescale 1ns/1ps
/* FPU command controller
   dispatches an opcode to add/sub or the multiplier and holds cmd_end until end_ack */
module fpu_control (
  input  logic             clk,
  input  logic             arst,
  input  logic             op_written,
  input  fpu_pkg::fpu_op_e operation,
  input  logic             mul_done,
  input  logic             end_ack,
  output logic             op_taken,
  output logic             mul_start,
  output logic             load_result,
  output logic             write_back,
  output logic             cmd_end,
  output logic             busy
);

  fpu_pkg::ctrl_state_e state;
  fpu_pkg::ctrl_state_e next_state;

  always_comb begin
    next_state = state;
    case (state)
      fpu_pkg::ctrl_idle:
        if (op_written) begin
          if (operation == fpu_pkg::op_mul) next_state = fpu_pkg::ctrl_mul_wait;
          else next_state = fpu_pkg::ctrl_exec;
        end
      // multiplier finished, go load its product
      fpu_pkg::ctrl_mul_wait:
        if (mul_done) next_state = fpu_pkg::ctrl_exec;
      fpu_pkg::ctrl_exec:
        next_state = fpu_pkg::ctrl_done;
      // ack only counts once cmd_end is visible to the host
      fpu_pkg::ctrl_done:
        if (end_ack && cmd_end) next_state = fpu_pkg::ctrl_idle;
      default:
        next_state = fpu_pkg::ctrl_idle;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state       <= fpu_pkg::ctrl_idle;
      op_taken    <= 1'b0;
      mul_start   <= 1'b0;
      load_result <= 1'b0;
      write_back  <= 1'b0;
      cmd_end     <= 1'b0;
      busy        <= 1'b0;
    end else begin
      state       <= next_state;
      op_taken    <= (state == fpu_pkg::ctrl_idle) && (next_state != fpu_pkg::ctrl_idle);
      mul_start   <= next_state == fpu_pkg::ctrl_mul_wait;
      load_result <= next_state == fpu_pkg::ctrl_exec;
      busy        <= next_state != fpu_pkg::ctrl_idle;
      // cmd_end one cycle after entering done, the result register is settled by then
      cmd_end     <= (state == fpu_pkg::ctrl_done) && (next_state == fpu_pkg::ctrl_done);
      write_back  <= (state == fpu_pkg::ctrl_done) && !cmd_end;
    end
  end

endmodule

// File: fpu_mul.sv
`timescale 1ns/1ps
/* FPU multiplier
   sequential shift-and-add mantissa product with exponent sum and sign */
module fpu_mul #(
  parameter int mant_width = 24
) (
  input  logic                           clk,
  input  logic                           arst,
  input  logic [fpu_pkg::word_width-1:0] operand_a,
  input  logic [fpu_pkg::word_width-1:0] operand_b,
  input  logic                           mul_start,
  output logic                           mul_done,
  output logic [fpu_pkg::word_width-1:0] prod_word
);

  localparam int fw = fpu_pkg::frac_width;
  localparam int ew = fpu_pkg::exp_width;
  localparam int pw = 2 * mant_width + 1;
  localparam int cw = $clog2(mant_width + 1);

  fpu_pkg::mul_state_e state;
  fpu_pkg::mul_state_e next_state;

  logic [mant_width-1:0] a_mant;
  logic [mant_width-1:0] b_mant;
  logic [mant_width-1:0] multiplicand;
  logic [mant_width-1:0] upper;
  logic [mant_width-1:0] upper_sh;
  logic [pw-1:0] product;
  logic [cw-1:0] round_cnt;
  logic [ew-1:0] a_exp;
  logic [ew-1:0] b_exp;
  logic [ew-1:0] prod_exp;
  logic prod_sign;

  assign a_exp    = operand_a[fw +: ew];
  assign b_exp    = operand_b[fw +: ew];
  assign a_mant   = mant_width'({a_exp != '0, operand_a[fw-1:0]});
  assign b_mant   = mant_width'({b_exp != '0, operand_b[fw-1:0]});
  assign upper    = product[2*mant_width-1:mant_width];
  assign upper_sh = upper << 1;
  // 1x.xxx product bumps the exponent
  assign prod_exp  = a_exp + b_exp - fpu_pkg::exp_bias + ew'(upper[mant_width-1]);
  assign prod_sign = operand_a[fpu_pkg::word_width-1] ^ operand_b[fpu_pkg::word_width-1];

  always_comb begin
    next_state = state;
    case (state)
      fpu_pkg::mul_idle:  if (mul_start) next_state = fpu_pkg::mul_start;
      fpu_pkg::mul_start: next_state = fpu_pkg::mul_add;
      fpu_pkg::mul_add:   next_state = fpu_pkg::mul_shift;
      fpu_pkg::mul_shift:
        if (round_cnt == cw'(mant_width)) next_state = fpu_pkg::mul_set;
        else next_state = fpu_pkg::mul_add;
      fpu_pkg::mul_set:   next_state = fpu_pkg::mul_valid;
      fpu_pkg::mul_valid: if (!mul_start) next_state = fpu_pkg::mul_idle;
      default:            next_state = fpu_pkg::mul_idle;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state     <= fpu_pkg::mul_idle;
      round_cnt <= '0;
      mul_done  <= 1'b0;
    end else begin
      state    <= next_state;
      mul_done <= next_state == fpu_pkg::mul_valid;
      if (state == fpu_pkg::mul_start) round_cnt <= '0;
      else if (state == fpu_pkg::mul_add) round_cnt <= round_cnt + 1'b1;
    end
  end

  // low half holds the multiplier, shifted out as the product grows
  always_ff @(posedge clk) begin
    case (state)
      fpu_pkg::mul_start: begin
        multiplicand <= a_mant;
        product      <= pw'(b_mant);
      end
      fpu_pkg::mul_add:
        if (product[0]) product[pw-1:mant_width] <= product[pw-1:mant_width] + multiplicand;
      fpu_pkg::mul_shift:
        product <= product >> 1;
      fpu_pkg::mul_set:
        if (upper[mant_width-1]) prod_word <= {prod_sign, prod_exp, upper[mant_width-2 -: fw]};
        else prod_word <= {prod_sign, prod_exp, upper_sh[mant_width-2 -: fw]};
      default: ;
    endcase
  end

endmodule

// File: fpu_pkg.sv
/* FPU shared definitions
   single precision format, register map and FSM encodings */
package fpu_pkg;

  // packed single precision word
  localparam int frac_width = 23;
  localparam int exp_width  = 8;
  localparam int word_width = 32;
  localparam logic [exp_width-1:0] exp_bias = 8'd127;

  // byte-wide register bus map
  localparam int addr_width = 4;
  localparam logic [addr_width-1:0] addr_a0 = 4'd0;
  localparam logic [addr_width-1:0] addr_b0 = 4'd4;
  localparam logic [addr_width-1:0] addr_op = 4'd8;
  localparam logic [addr_width-1:0] addr_r0 = 4'd9;

  // host visible operation codes
  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_mul = 4'd2
  } fpu_op_e;

  // command sequencer
  typedef enum logic [1:0] {
    ctrl_idle,
    ctrl_exec,
    ctrl_mul_wait,
    ctrl_done
  } ctrl_state_e;

  // shift-and-add multiplier
  typedef enum logic [2:0] {
    mul_idle,
    mul_start,
    mul_add,
    mul_shift,
    mul_set,
    mul_valid
  } mul_state_e;

endpackage

// File: fpu_regs.sv
`timescale 1ns/1ps
/* FPU register bank
   byte-wide bus decode for the operands and opcode, read mux and result write-back */
module fpu_regs (
  input  logic                               clk,
  input  logic                               arst,
  input  logic [7:0]                         databus_in,
  output logic [7:0]                         databus_out,
  input  logic [fpu_pkg::addr_width-1:0]     addr,
  input  logic                               cs,
  input  logic                               rd,
  input  logic                               wr,
  input  logic                               op_taken,
  input  logic                               write_back,
  input  logic [fpu_pkg::word_width-1:0]     result_word,
  output logic [fpu_pkg::word_width-1:0]     operand_a,
  output logic [fpu_pkg::word_width-1:0]     operand_b,
  output fpu_pkg::fpu_op_e                   operation,
  output logic                               op_written
);

  // 1.0 in single precision
  localparam logic [fpu_pkg::word_width-1:0] one_word = 32'h3f80_0000;

  logic [fpu_pkg::addr_width-1:0] off_a;
  logic [fpu_pkg::addr_width-1:0] off_b;
  logic [fpu_pkg::addr_width-1:0] off_r;
  logic hit_a;
  logic hit_b;
  logic hit_r;
  logic wr_en;
  logic rd_en;

  // byte offset inside each 4-byte field, wraps out of range otherwise
  assign off_a = addr - fpu_pkg::addr_a0;
  assign off_b = addr - fpu_pkg::addr_b0;
  assign off_r = addr - fpu_pkg::addr_r0;
  assign hit_a = off_a < 4;
  assign hit_b = off_b < 4;
  assign hit_r = off_r < 4;

  assign wr_en = !cs && !wr;
  assign rd_en = !cs && !rd;

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      operand_a  <= one_word;
      operand_b  <= one_word;
      operation  <= fpu_pkg::op_add;
      op_written <= 1'b0;
    end else begin
      if (op_taken) op_written <= 1'b0;
      if (wr_en) begin
        if (hit_a) operand_a[8*off_a[1:0] +: 8] <= databus_in;
        if (hit_b) operand_b[8*off_b[1:0] +: 8] <= databus_in;
        // a new opcode write wins over the acknowledge
        if (addr == fpu_pkg::addr_op) begin
          operation  <= fpu_pkg::fpu_op_e'(databus_in[3:0]);
          op_written <= 1'b1;
        end
      end
      // result chains back into A
      if (write_back) operand_a <= result_word;
    end
  end

  always_comb begin
    databus_out = '0;
    if (rd_en) begin
      if (hit_a) databus_out = operand_a[8*off_a[1:0] +: 8];
      else if (hit_b) databus_out = operand_b[8*off_b[1:0] +: 8];
      else if (addr == fpu_pkg::addr_op) databus_out = {4'b0000, operation};
      else if (hit_r) databus_out = result_word[8*off_r[1:0] +: 8];
    end
  end

endmodule

// File: fpu_result.sv
`timescale 1ns/1ps
/* FPU result stage
   normalizes and packs the add/sub sum, registers it or the product */
module fpu_result (
  input  logic                                  clk,
  input  logic                                  arst,
  input  fpu_pkg::fpu_op_e                      operation,
  input  logic                                  sum_sign,
  input  logic [fpu_pkg::frac_width+2:0]        sum_mag,
  input  logic signed [fpu_pkg::exp_width-1:0]  sum_exp,
  input  logic                                  sum_zero,
  input  logic [fpu_pkg::word_width-1:0]        prod_word,
  input  logic                                  load_result,
  output logic [fpu_pkg::word_width-1:0]        result_word
);

  localparam int fw = fpu_pkg::frac_width;
  localparam int ew = fpu_pkg::exp_width;

  logic [fw+2:0] norm_mag;
  logic signed [ew-1:0] norm_exp;
  logic [4:0] lead;
  logic [4:0] lshift;
  logic [ew-1:0] biased_exp;
  logic [fpu_pkg::word_width-1:0] sum_word;

  always_comb begin
    // highest set bit below the hidden position
    lead = '0;
    for (int i = 0; i <= fw; i++) begin
      if (sum_mag[i]) lead = 5'(i);
    end
    lshift   = 5'(fw) - lead;
    norm_mag = sum_mag;
    norm_exp = sum_exp;
    if (sum_mag[fw+2]) begin
      norm_mag = sum_mag >> 2;
      norm_exp = sum_exp + 8'sd2;
    end else if (sum_mag[fw+1]) begin
      norm_mag = sum_mag >> 1;
      norm_exp = sum_exp + 8'sd1;
    end else begin
      norm_mag = sum_mag << lshift;
      norm_exp = sum_exp - signed'({3'b000, lshift});
    end
  end

  assign biased_exp = norm_exp + fpu_pkg::exp_bias;
  assign sum_word   = sum_zero ? '0 : {sum_sign, biased_exp, norm_mag[fw-1:0]};

  always_ff @(posedge clk or posedge arst) begin
    if (arst) result_word <= '0;
    else if (load_result) begin
      if (operation == fpu_pkg::op_mul) result_word <= prod_word;
      else result_word <= sum_word;
    end
  end

endmodule

// File: fpu_stim.txt
// columns: opcode operand_a operand_b expected_result, all hex
// opcode bit 4 set: A is not written, the A column is the expected chained value
00 3F800000 40000000 40400000
00 3FC00000 3FC00000 40400000
00 40800000 BF800000 40400000
00 3F800000 C0800000 C0400000
00 40A00000 C0A00000 00000000
00 40200000 40600000 40C00000
00 3F000000 3E800000 3F400000
00 00000000 40000000 40000000
01 40400000 3F800000 40000000
01 3FC00000 3FA00000 3E800000
01 3F800000 3F7FC000 3A800000
01 3F800000 40400000 C0000000
01 40000000 C0000000 40800000
01 41200000 41200000 00000000
02 40000000 40400000 40C00000
10 40C00000 3F800000 40E00000
12 40E00000 40000000 41600000
11 41600000 40800000 41200000
02 3FC00000 3FC00000 40100000
02 C0000000 40400000 C0C00000
02 BFC00000 C0200000 40700000
02 3F000000 BF400000 BEC00000

// File: fpu_top.sv
`timescale 1ns/1ps
/* FPU coprocessor top
   bus registers, controller, add/sub and multiply datapaths, result stage */
module fpu_top (
  input  logic                           clk,
  input  logic                           arst,
  input  logic [7:0]                     databus_in,
  output logic [7:0]                     databus_out,
  input  logic [fpu_pkg::addr_width-1:0] addr,
  input  logic                           cs,
  input  logic                           rd,
  input  logic                           wr,
  input  logic                           end_ack,
  output logic                           cmd_end,
  output logic                           busy
);

  // hidden bit plus stored fraction
  localparam int mant_width = fpu_pkg::frac_width + 1;

  logic [fpu_pkg::word_width-1:0] operand_a;
  logic [fpu_pkg::word_width-1:0] operand_b;
  logic [fpu_pkg::word_width-1:0] prod_word;
  logic [fpu_pkg::word_width-1:0] result_word;
  fpu_pkg::fpu_op_e operation;
  logic op_written;
  logic op_taken;
  logic mul_start;
  logic mul_done;
  logic load_result;
  logic write_back;
  logic sum_sign;
  logic sum_zero;
  logic [fpu_pkg::frac_width+2:0] sum_mag;
  logic signed [fpu_pkg::exp_width-1:0] sum_exp;

  fpu_regs u_regs (
    .clk, .arst, .databus_in, .databus_out, .addr, .cs, .rd, .wr,
    .op_taken, .write_back, .result_word,
    .operand_a, .operand_b, .operation, .op_written
  );

  fpu_control u_control (
    .clk, .arst, .op_written, .operation, .mul_done, .end_ack,
    .op_taken, .mul_start, .load_result, .write_back, .cmd_end, .busy
  );

  fpu_add_sub u_add_sub (
    .operand_a, .operand_b, .operation,
    .sum_sign, .sum_mag, .sum_exp, .sum_zero, .a_zero()
  );

  fpu_mul #(.mant_width(mant_width)) u_mul (
    .clk, .arst, .operand_a, .operand_b, .mul_start, .mul_done, .prod_word
  );

  fpu_result u_result (
    .clk, .arst, .operation, .sum_sign, .sum_mag, .sum_exp, .sum_zero,
    .prod_word, .load_result, .result_word
  );

endmodule

// File: run.sh
#!/bin/sh
# build the FPU testbench with Verilator, run it and search the log for the pass line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fpu -f sources.f \
  && ./obj_dir/Vtb_fpu 2>&1 | tee sim.log
grep -q "PASS: all tests" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sources.f
fpu_pkg.sv
fpu_regs.sv
fpu_control.sv
fpu_add_sub.sv
fpu_mul.sv
fpu_result.sv
fpu_top.sv
fpu_assert.sv
tb_fpu.sv

// File: tb_fpu.sv
`timescale 1ns/1ps
/* FPU testbench
   runs the operations of the stimulus file through the byte-wide register bus */
module tb_fpu;

  localparam int max_wait = 200;

  logic clk;
  logic arst;
  logic [7:0] databus_in;
  logic [7:0] databus_out;
  logic [fpu_pkg::addr_width-1:0] addr;
  logic cs;
  logic rd;
  logic wr;
  logic end_ack;
  logic cmd_end;
  logic busy;

  int fd;
  int fields;
  int tests_run;
  string line;
  logic [7:0] op_code;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] expected;
  logic [31:0] word;
  logic [7:0] byte_val;

  fpu_top UUT (
    .clk, .arst, .databus_in, .databus_out, .addr, .cs, .rd, .wr,
    .end_ack, .cmd_end, .busy
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] want,
                             input string what);
    if (actual !== want) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, actual, want);
      abort_run();
    end
  endtask

  // one bus cycle per byte from the drive point after a rising edge
  task automatic bus_write(input logic [fpu_pkg::addr_width-1:0] where, input logic [7:0] data);
    addr = where;
    databus_in = data;
    cs = 1'b0;
    wr = 1'b0;
    @(posedge clk);
    #5;
    cs = 1'b1;
    wr = 1'b1;
  endtask

  task automatic bus_read(input logic [fpu_pkg::addr_width-1:0] where, output logic [7:0] data);
    addr = where;
    cs = 1'b0;
    rd = 1'b0;
    // combinational read mux sampled well before the next edge
    #40;
    data = databus_out;
    @(posedge clk);
    #5;
    cs = 1'b1;
    rd = 1'b1;
  endtask

  task automatic write_word(input logic [fpu_pkg::addr_width-1:0] base, input logic [31:0] value);
    for (int i = 0; i < 4; i++) begin
      bus_write(base + 4'(i), value[8*i +: 8]);
    end
  endtask

  task automatic read_word(input logic [fpu_pkg::addr_width-1:0] base, output logic [31:0] value);
    logic [7:0] data;
    for (int i = 0; i < 4; i++) begin
      bus_read(base + 4'(i), data);
      value[8*i +: 8] = data;
    end
  endtask

  task automatic wait_cmd_end();
    int cycles;
    cycles = 0;
    while (!cmd_end) begin
      @(posedge clk);
      #5;
      cycles++;
      if (cycles > max_wait) begin
        $display("timeout: cmd_end did not rise within %0d cycles", max_wait);
        abort_run();
      end
    end
  endtask

  task automatic acknowledge();
    int cycles;
    cycles = 0;
    end_ack = 1'b1;
    while (cmd_end) begin
      @(posedge clk);
      #5;
      cycles++;
      if (cycles > max_wait) begin
        $display("timeout: cmd_end stayed high %0d cycles after end_ack", max_wait);
        abort_run();
      end
    end
    end_ack = 1'b0;
    // cmd_end drops on the first edge that sees end_ack
    check_value(32'(cycles), 32'd1, "cycles from end_ack to cmd_end low");
    check_value(32'(busy), 32'd0, "busy after acknowledge");
  endtask

  // bit 4 of the opcode column keeps A from the previous result
  task automatic run_test(input int num, input logic [7:0] op, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] want);
    logic [31:0] value;
    if (op[4]) begin
      read_word(fpu_pkg::addr_a0, value);
      check_value(value, a, $sformatf("test %0d chained operand A", num));
    end else begin
      write_word(fpu_pkg::addr_a0, a);
    end
    write_word(fpu_pkg::addr_b0, b);
    bus_write(fpu_pkg::addr_op, {4'b0000, op[3:0]});
    wait_cmd_end();
    check_value(32'(busy), 32'd1, $sformatf("test %0d busy with cmd_end", num));
    read_word(fpu_pkg::addr_r0, value);
    check_value(value, want, $sformatf("test %0d result", num));
    read_word(fpu_pkg::addr_a0, value);
    check_value(value, want, $sformatf("test %0d result written back to A", num));
    // still waiting for the host
    check_value(32'(cmd_end), 32'd1, $sformatf("test %0d cmd_end held before end_ack", num));
    acknowledge();
  endtask

  initial begin
    arst = 1'b1;
    cs = 1'b1;
    rd = 1'b1;
    wr = 1'b1;
    addr = '0;
    databus_in = '0;
    end_ack = 1'b0;
    tests_run = 0;
    repeat (16) @(posedge clk);
    #5;
    arst = 1'b0;

    // reset state of the register bank
    read_word(fpu_pkg::addr_a0, word);
    check_value(word, 32'h3f80_0000, "operand A after reset");
    read_word(fpu_pkg::addr_b0, word);
    check_value(word, 32'h3f80_0000, "operand B after reset");
    bus_read(fpu_pkg::addr_op, byte_val);
    check_value(32'(byte_val), 32'd0, "opcode after reset");
    check_value(32'(cmd_end), 32'd0, "cmd_end after reset");
    check_value(32'(busy), 32'd0, "busy after reset");

    fd = $fopen("fpu_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file fpu_stim.txt");
      abort_run();
    end
    while ($fgets(line, fd) > 0) begin
      fields = $sscanf(line, "%h %h %h %h", op_code, op_a, op_b, expected);
      // comment and blank lines scan no field
      if (fields == 4) begin
        tests_run++;
        run_test(tests_run, op_code, op_a, op_b, expected);
      end else if (fields > 0) begin
        $display("stimulus line has %0d of 4 fields: %s", fields, line);
        abort_run();
      end
    end
    $fclose(fd);

    if (tests_run == 0) begin
      $display("the stimulus file held no test lines");
      abort_run();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule
